/* zstd_axi_pkg.sv */
package zstd_axi_pkg;

  // Reader-side and CSR-side ID width
  localparam int AXI_S_ID_W = 4;
  // Reader index carried in the upper ID bits
  localparam int AXI_PORT_W = 2;
  localparam int AXI_M_ID_W = AXI_S_ID_W + AXI_PORT_W;

  localparam int AXI_LEN_W   = 8;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_RESP_W  = 2;

  localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [AXI_RESP_W-1:0] AXI_RESP_SLVERR = 2'b10;

  // Memory-side ID, raw or split into reader index and source ID
  typedef union packed {
    logic [AXI_M_ID_W-1:0] raw;
    struct packed {
      logic [AXI_PORT_W-1:0] port;
      logic [AXI_S_ID_W-1:0] src_id;
    } split;
  } zstd_mem_id_t;

endpackage

/* zstd_csr_pkg.sv */
package zstd_csr_pkg;

  // Byte addresses of the decoder control registers
  localparam int unsigned CSR_RESET         = 32'h00;
  localparam int unsigned CSR_START         = 32'h08;
  localparam int unsigned CSR_INPUT_BUFFER  = 32'h10;
  localparam int unsigned CSR_OUTPUT_BUFFER = 32'h18;

  localparam int CSR_COUNT = 4;

  // Register index sits in address bits 4:3
  localparam int CSR_IDX_W   = 2;
  localparam int CSR_IDX_LSB = 3;

endpackage

/* zstd_csr_regs.sv */
`timescale 1ns/1ps

module zstd_csr_regs
  import zstd_axi_pkg::*, zstd_csr_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 64,
  parameter int STRB_W = 8
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic [AXI_S_ID_W-1:0] aw_id,
  input  logic [ADDR_W-1:0]     aw_addr,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  logic [DATA_W-1:0]     w_data,
  input  logic [STRB_W-1:0]     w_strb,
  input  logic                  w_valid,
  output logic                  w_ready,
  output logic [AXI_S_ID_W-1:0] b_id,
  output logic [AXI_RESP_W-1:0] b_resp,
  output logic                  b_valid,
  input  logic                  b_ready,

  input  logic [AXI_S_ID_W-1:0] ar_id,
  input  logic [ADDR_W-1:0]     ar_addr,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output logic [AXI_S_ID_W-1:0] r_id,
  output logic [DATA_W-1:0]     r_data,
  output logic [AXI_RESP_W-1:0] r_resp,
  output logic                  r_last,
  output logic                  r_valid,
  input  logic                  r_ready,

  output logic                  soft_reset
);

  if (STRB_W != DATA_W / 8) begin : g_strb_check
    $error("STRB_W must equal DATA_W/8");
  end

  function automatic logic addr_known(input logic [ADDR_W-1:0] addr);
    return addr inside {ADDR_W'(CSR_RESET), ADDR_W'(CSR_START),
                        ADDR_W'(CSR_INPUT_BUFFER), ADDR_W'(CSR_OUTPUT_BUFFER)};
  endfunction

  // RESET has no storage, it always reads zero
  logic [DATA_W-1:0]    regs [1:CSR_COUNT-1];
  logic [CSR_IDX_W-1:0] aw_idx;
  logic [CSR_IDX_W-1:0] ar_idx;
  logic                 aw_known;
  logic                 ar_known;
  logic                 wr_fire;
  logic                 rd_fire;
  logic [DATA_W-1:0]    rd_data;

  assign aw_idx   = aw_addr[CSR_IDX_LSB +: CSR_IDX_W];
  assign ar_idx   = ar_addr[CSR_IDX_LSB +: CSR_IDX_W];
  assign aw_known = addr_known(aw_addr);
  assign ar_known = addr_known(ar_addr);

  // AW and W are taken together, one write in flight
  assign wr_fire  = aw_valid && w_valid && !b_valid;
  assign aw_ready = wr_fire;
  assign w_ready  = wr_fire;

  assign rd_fire  = ar_valid && !r_valid;
  assign ar_ready = rd_fire;
  assign r_last   = 1'b1;

  always_ff @(posedge clk) begin
    if (rst || soft_reset) begin
      for (int i = 1; i < CSR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire && aw_known) begin
      for (int i = 1; i < CSR_COUNT; i++) begin
        if (aw_idx == CSR_IDX_W'(i)) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (w_strb[b]) begin
              regs[i][8*b +: 8] <= w_data[8*b +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      b_valid    <= 1'b0;
      r_valid    <= 1'b0;
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= wr_fire && (aw_addr == ADDR_W'(CSR_RESET)) && (|w_strb);
      if (wr_fire) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
      if (rd_fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    for (int i = 1; i < CSR_COUNT; i++) begin
      if (ar_known && ar_idx == CSR_IDX_W'(i)) begin
        rd_data = regs[i];
      end
    end
  end

  // Response payload held until taken
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b_id   <= aw_id;
      b_resp <= aw_known ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
    if (rd_fire) begin
      r_id   <= ar_id;
      r_data <= rd_data;
      r_resp <= ar_known ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid && $stable(b_id));

  a_soft_reset_pulse: assert property (@(posedge clk) disable iff (rst)
    soft_reset |=> !soft_reset);

endmodule

/* zstd_mem_read_mux.sv */
`timescale 1ns/1ps

module zstd_mem_read_mux
  import zstd_axi_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 64
) (
  input  logic                   clk,
  input  logic                   rst,

  input  logic [AXI_S_ID_W-1:0]  fh_ar_id,
  input  logic [ADDR_W-1:0]      fh_ar_addr,
  input  logic [AXI_LEN_W-1:0]   fh_ar_len,
  input  logic [AXI_SIZE_W-1:0]  fh_ar_size,
  input  logic [AXI_BURST_W-1:0] fh_ar_burst,
  input  logic                   fh_ar_valid,
  output logic                   fh_ar_ready,
  output logic [AXI_S_ID_W-1:0]  fh_r_id,
  output logic [DATA_W-1:0]      fh_r_data,
  output logic [AXI_RESP_W-1:0]  fh_r_resp,
  output logic                   fh_r_last,
  output logic                   fh_r_valid,
  input  logic                   fh_r_ready,

  input  logic [AXI_S_ID_W-1:0]  bh_ar_id,
  input  logic [ADDR_W-1:0]      bh_ar_addr,
  input  logic [AXI_LEN_W-1:0]   bh_ar_len,
  input  logic [AXI_SIZE_W-1:0]  bh_ar_size,
  input  logic [AXI_BURST_W-1:0] bh_ar_burst,
  input  logic                   bh_ar_valid,
  output logic                   bh_ar_ready,
  output logic [AXI_S_ID_W-1:0]  bh_r_id,
  output logic [DATA_W-1:0]      bh_r_data,
  output logic [AXI_RESP_W-1:0]  bh_r_resp,
  output logic                   bh_r_last,
  output logic                   bh_r_valid,
  input  logic                   bh_r_ready,

  input  logic [AXI_S_ID_W-1:0]  raw_ar_id,
  input  logic [ADDR_W-1:0]      raw_ar_addr,
  input  logic [AXI_LEN_W-1:0]   raw_ar_len,
  input  logic [AXI_SIZE_W-1:0]  raw_ar_size,
  input  logic [AXI_BURST_W-1:0] raw_ar_burst,
  input  logic                   raw_ar_valid,
  output logic                   raw_ar_ready,
  output logic [AXI_S_ID_W-1:0]  raw_r_id,
  output logic [DATA_W-1:0]      raw_r_data,
  output logic [AXI_RESP_W-1:0]  raw_r_resp,
  output logic                   raw_r_last,
  output logic                   raw_r_valid,
  input  logic                   raw_r_ready,

  output zstd_mem_id_t           mem_ar_id,
  output logic [ADDR_W-1:0]      mem_ar_addr,
  output logic [AXI_LEN_W-1:0]   mem_ar_len,
  output logic [AXI_SIZE_W-1:0]  mem_ar_size,
  output logic [AXI_BURST_W-1:0] mem_ar_burst,
  output logic                   mem_ar_valid,
  input  logic                   mem_ar_ready,
  input  zstd_mem_id_t           mem_r_id,
  input  logic [DATA_W-1:0]      mem_r_data,
  input  logic [AXI_RESP_W-1:0]  mem_r_resp,
  input  logic                   mem_r_last,
  input  logic                   mem_r_valid,
  output logic                   mem_r_ready
);

  localparam int N_PORTS = 3;

  logic [N_PORTS-1:0]     ar_valid_v;
  logic [N_PORTS-1:0]     ar_ready_v;
  logic [N_PORTS-1:0]     r_valid_v;
  logic [N_PORTS-1:0]     r_ready_v;
  logic [AXI_S_ID_W-1:0]  ar_id_v    [N_PORTS];
  logic [ADDR_W-1:0]      ar_addr_v  [N_PORTS];
  logic [AXI_LEN_W-1:0]   ar_len_v   [N_PORTS];
  logic [AXI_SIZE_W-1:0]  ar_size_v  [N_PORTS];
  logic [AXI_BURST_W-1:0] ar_burst_v [N_PORTS];

  logic [AXI_PORT_W-1:0]  rr_ptr;
  logic [AXI_PORT_W-1:0]  pick;
  logic [AXI_PORT_W-1:0]  grant;
  logic [AXI_PORT_W-1:0]  hold_idx;
  logic                   hold_vld;
  logic                   ar_fire;
  logic [AXI_PORT_W-1:0]  r_port;

  // Index 0 is the frame header reader, 2 the raw block reader
  assign ar_valid_v = {raw_ar_valid, bh_ar_valid, fh_ar_valid};
  assign ar_id_v    = '{fh_ar_id, bh_ar_id, raw_ar_id};
  assign ar_addr_v  = '{fh_ar_addr, bh_ar_addr, raw_ar_addr};
  assign ar_len_v   = '{fh_ar_len, bh_ar_len, raw_ar_len};
  assign ar_size_v  = '{fh_ar_size, bh_ar_size, raw_ar_size};
  assign ar_burst_v = '{fh_ar_burst, bh_ar_burst, raw_ar_burst};
  assign {raw_ar_ready, bh_ar_ready, fh_ar_ready} = ar_ready_v;

  // First requester at or after the pointer
  always_comb begin
    int cand;
    pick = rr_ptr;
    for (int k = N_PORTS - 1; k >= 0; k--) begin
      cand = (int'(rr_ptr) + k) % N_PORTS;
      if (ar_valid_v[cand]) begin
        pick = AXI_PORT_W'(cand);
      end
    end
  end

  assign grant   = hold_vld ? hold_idx : pick;
  assign ar_fire = mem_ar_valid && mem_ar_ready;

  always_comb begin
    mem_ar_id.split.port   = grant;
    mem_ar_id.split.src_id = ar_id_v[grant];
    mem_ar_addr            = ar_addr_v[grant];
    mem_ar_len             = ar_len_v[grant];
    mem_ar_size            = ar_size_v[grant];
    mem_ar_burst           = ar_burst_v[grant];
    mem_ar_valid           = ar_valid_v[grant];
    for (int i = 0; i < N_PORTS; i++) begin
      ar_ready_v[i] = mem_ar_ready && (grant == AXI_PORT_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr   <= '0;
      hold_vld <= 1'b0;
      hold_idx <= '0;
    end else if (ar_fire) begin
      rr_ptr   <= (grant == AXI_PORT_W'(N_PORTS - 1)) ? '0 : grant + 1'b1;
      hold_vld <= 1'b0;
    end else if (mem_ar_valid) begin
      // Stalled request keeps its grant
      hold_vld <= 1'b1;
      hold_idx <= grant;
    end
  end

  // Read beats steered by the port field of the ID
  assign r_port    = mem_r_id.split.port;
  assign r_ready_v = {raw_r_ready, bh_r_ready, fh_r_ready};
  assign {raw_r_valid, bh_r_valid, fh_r_valid} = r_valid_v;

  always_comb begin
    mem_r_ready = 1'b0;
    for (int i = 0; i < N_PORTS; i++) begin
      r_valid_v[i] = mem_r_valid && (r_port == AXI_PORT_W'(i));
      if (r_port == AXI_PORT_W'(i)) begin
        mem_r_ready = r_ready_v[i];
      end
    end
  end

  assign fh_r_id    = mem_r_id.split.src_id;
  assign fh_r_data  = mem_r_data;
  assign fh_r_resp  = mem_r_resp;
  assign fh_r_last  = mem_r_last;
  assign bh_r_id    = mem_r_id.split.src_id;
  assign bh_r_data  = mem_r_data;
  assign bh_r_resp  = mem_r_resp;
  assign bh_r_last  = mem_r_last;
  assign raw_r_id   = mem_r_id.split.src_id;
  assign raw_r_data = mem_r_data;
  assign raw_r_resp = mem_r_resp;
  assign raw_r_last = mem_r_last;

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar_id));

  a_r_port: assert property (@(posedge clk) disable iff (rst)
    mem_r_valid |-> int'(r_port) < N_PORTS);

endmodule

/* zstd_dec_wrapper.sv */
`timescale 1ns/1ps

module zstd_dec_wrapper
  import zstd_axi_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 64,
  parameter int STRB_W = 8
) (
  input  logic                   clk,
  input  logic                   rst,

  input  logic [AXI_S_ID_W-1:0]  aw_id,
  input  logic [ADDR_W-1:0]      aw_addr,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  logic [DATA_W-1:0]      w_data,
  input  logic [STRB_W-1:0]      w_strb,
  input  logic                   w_valid,
  output logic                   w_ready,
  output logic [AXI_S_ID_W-1:0]  b_id,
  output logic [AXI_RESP_W-1:0]  b_resp,
  output logic                   b_valid,
  input  logic                   b_ready,
  input  logic [AXI_S_ID_W-1:0]  ar_id,
  input  logic [ADDR_W-1:0]      ar_addr,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output logic [AXI_S_ID_W-1:0]  r_id,
  output logic [DATA_W-1:0]      r_data,
  output logic [AXI_RESP_W-1:0]  r_resp,
  output logic                   r_last,
  output logic                   r_valid,
  input  logic                   r_ready,

  input  logic [AXI_S_ID_W-1:0]  fh_ar_id,
  input  logic [ADDR_W-1:0]      fh_ar_addr,
  input  logic [AXI_LEN_W-1:0]   fh_ar_len,
  input  logic [AXI_SIZE_W-1:0]  fh_ar_size,
  input  logic [AXI_BURST_W-1:0] fh_ar_burst,
  input  logic                   fh_ar_valid,
  output logic                   fh_ar_ready,
  output logic [AXI_S_ID_W-1:0]  fh_r_id,
  output logic [DATA_W-1:0]      fh_r_data,
  output logic [AXI_RESP_W-1:0]  fh_r_resp,
  output logic                   fh_r_last,
  output logic                   fh_r_valid,
  input  logic                   fh_r_ready,

  input  logic [AXI_S_ID_W-1:0]  bh_ar_id,
  input  logic [ADDR_W-1:0]      bh_ar_addr,
  input  logic [AXI_LEN_W-1:0]   bh_ar_len,
  input  logic [AXI_SIZE_W-1:0]  bh_ar_size,
  input  logic [AXI_BURST_W-1:0] bh_ar_burst,
  input  logic                   bh_ar_valid,
  output logic                   bh_ar_ready,
  output logic [AXI_S_ID_W-1:0]  bh_r_id,
  output logic [DATA_W-1:0]      bh_r_data,
  output logic [AXI_RESP_W-1:0]  bh_r_resp,
  output logic                   bh_r_last,
  output logic                   bh_r_valid,
  input  logic                   bh_r_ready,

  input  logic [AXI_S_ID_W-1:0]  raw_ar_id,
  input  logic [ADDR_W-1:0]      raw_ar_addr,
  input  logic [AXI_LEN_W-1:0]   raw_ar_len,
  input  logic [AXI_SIZE_W-1:0]  raw_ar_size,
  input  logic [AXI_BURST_W-1:0] raw_ar_burst,
  input  logic                   raw_ar_valid,
  output logic                   raw_ar_ready,
  output logic [AXI_S_ID_W-1:0]  raw_r_id,
  output logic [DATA_W-1:0]      raw_r_data,
  output logic [AXI_RESP_W-1:0]  raw_r_resp,
  output logic                   raw_r_last,
  output logic                   raw_r_valid,
  input  logic                   raw_r_ready,

  output zstd_mem_id_t           mem_ar_id,
  output logic [ADDR_W-1:0]      mem_ar_addr,
  output logic [AXI_LEN_W-1:0]   mem_ar_len,
  output logic [AXI_SIZE_W-1:0]  mem_ar_size,
  output logic [AXI_BURST_W-1:0] mem_ar_burst,
  output logic                   mem_ar_valid,
  input  logic                   mem_ar_ready,
  input  zstd_mem_id_t           mem_r_id,
  input  logic [DATA_W-1:0]      mem_r_data,
  input  logic [AXI_RESP_W-1:0]  mem_r_resp,
  input  logic                   mem_r_last,
  input  logic                   mem_r_valid,
  output logic                   mem_r_ready
);

  logic soft_reset;
  logic mux_rst;

  // Write to RESET also restarts the read interconnect
  assign mux_rst = rst | soft_reset;

  zstd_csr_regs #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .STRB_W(STRB_W)
  ) u_csr_regs (
    .rst(rst),
    .*
  );

  zstd_mem_read_mux #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_mem_read_mux (
    .rst(mux_rst),
    .*
  );

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
  import zstd_axi_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [AXI_M_ID_W-1:0] ar_id,
  input  logic [ADDR_W-1:0]     ar_addr,
  input  logic [AXI_LEN_W-1:0]  ar_len,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output logic [AXI_M_ID_W-1:0] r_id,
  output logic [DATA_W-1:0]     r_data,
  output logic [AXI_RESP_W-1:0] r_resp,
  output logic                  r_last,
  output logic                  r_valid,
  input  logic                  r_ready
);

  logic [AXI_M_ID_W-1:0] q_id   [$];
  logic [ADDR_W-1:0]     q_addr [$];
  logic [AXI_LEN_W-1:0]  q_len  [$];
  int                    beat;

  // Beat k carries address plus k, memory ID in the top byte
  function automatic logic [DATA_W-1:0] beat_data(input logic [AXI_M_ID_W-1:0] id,
                                                  input logic [ADDR_W-1:0] addr,
                                                  input int k);
    logic [DATA_W-1:0] d;
    d = DATA_W'(addr) + DATA_W'(k);
    d[DATA_W-1 -: 8] = 8'(id);
    return d;
  endfunction

  initial begin
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r_id     = '0;
    r_data   = '0;
    r_resp   = '0;
    r_last   = 1'b0;
    beat     = 0;
  end

  // Sampled on the edge, driven 2 ns later
  always @(posedge clk) begin
    if (rst) begin
      q_id.delete();
      q_addr.delete();
      q_len.delete();
      beat = 0;
      #2;
      ar_ready = 1'b0;
      r_valid  = 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        q_id.push_back(ar_id);
        q_addr.push_back(ar_addr);
        q_len.push_back(ar_len);
      end
      if (r_valid && r_ready) begin
        if (r_last) begin
          void'(q_id.pop_front());
          void'(q_addr.pop_front());
          void'(q_len.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      #2;
      ar_ready = 1'b1;
      r_valid  = q_id.size() != 0;
      if (r_valid) begin
        r_id   = q_id[0];
        r_data = beat_data(q_id[0], q_addr[0], beat);
        r_resp = AXI_RESP_OKAY;
        r_last = beat == int'(q_len[0]);
      end
    end
  end

endmodule

/* tb_zstd_dec_wrapper.sv */
`timescale 1ns/1ps

module tb_zstd_dec_wrapper
  import zstd_axi_pkg::*, zstd_csr_pkg::*;
();

  localparam int ADDR_W = 16;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;

  localparam logic [ADDR_W-1:0] RST_A   = ADDR_W'(CSR_RESET);
  localparam logic [ADDR_W-1:0] START_A = ADDR_W'(CSR_START);
  localparam logic [ADDR_W-1:0] IN_A    = ADDR_W'(CSR_INPUT_BUFFER);
  localparam logic [ADDR_W-1:0] OUT_A   = ADDR_W'(CSR_OUTPUT_BUFFER);
  localparam logic [1:0]        OK      = AXI_RESP_OKAY;
  localparam logic [1:0]        ERR     = AXI_RESP_SLVERR;

  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] exp_data;
    logic [1:0]        exp_resp;
  } csr_op_t;

  typedef struct packed {
    logic [1:0]        port;
    logic [3:0]        src;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic              conc;
  } rd_op_t;

  localparam int CSR_ROWS = 20;
  localparam csr_op_t CSR_TBL [CSR_ROWS] = '{
    '{1'b1, START_A,  64'h1122_3344_5566_7788, 8'hff, 64'h0,                   OK },
    '{1'b0, START_A,  64'h0,                   8'h00, 64'h1122_3344_5566_7788, OK },
    '{1'b1, START_A,  64'haaaa_aaaa_aaaa_aaaa, 8'h0f, 64'h0,                   OK },
    '{1'b0, START_A,  64'h0,                   8'h00, 64'h1122_3344_aaaa_aaaa, OK },
    '{1'b1, IN_A,     64'hdead_beef_cafe_f00d, 8'hff, 64'h0,                   OK },
    '{1'b1, IN_A,     64'h0,                   8'hc0, 64'h0,                   OK },
    '{1'b0, IN_A,     64'h0,                   8'h00, 64'h0000_beef_cafe_f00d, OK },
    '{1'b1, OUT_A,    64'h0123_4567_89ab_cdef, 8'h81, 64'h0,                   OK },
    '{1'b0, OUT_A,    64'h0,                   8'h00, 64'h0100_0000_0000_00ef, OK },
    // Unknown addresses, 0x28 aliases the START index
    '{1'b1, 16'h0028, 64'hffff_ffff_ffff_ffff, 8'hff, 64'h0,                   ERR},
    '{1'b0, 16'h0028, 64'h0,                   8'h00, 64'h0,                   ERR},
    '{1'b0, 16'h000c, 64'h0,                   8'h00, 64'h0,                   ERR},
    '{1'b0, START_A,  64'h0,                   8'h00, 64'h1122_3344_aaaa_aaaa, OK },
    '{1'b0, IN_A,     64'h0,                   8'h00, 64'h0000_beef_cafe_f00d, OK },
    '{1'b0, OUT_A,    64'h0,                   8'h00, 64'h0100_0000_0000_00ef, OK },
    '{1'b0, RST_A,    64'h0,                   8'h00, 64'h0,                   OK },
    '{1'b1, RST_A,    64'h1,                   8'h01, 64'h0,                   OK },
    '{1'b0, START_A,  64'h0,                   8'h00, 64'h0,                   OK },
    '{1'b0, IN_A,     64'h0,                   8'h00, 64'h0,                   OK },
    '{1'b0, OUT_A,    64'h0,                   8'h00, 64'h0,                   OK }
  };

  // Rows with conc set are issued by all readers at once
  localparam int RD_ROWS = 13;
  localparam rd_op_t RD_TBL [RD_ROWS] = '{
    '{2'd0, 4'd3,  16'h1000, 8'd0,  1'b0},
    '{2'd1, 4'd5,  16'h2000, 8'd0,  1'b0},
    '{2'd2, 4'd9,  16'h3000, 8'd0,  1'b0},
    '{2'd0, 4'd1,  16'h1100, 8'd7,  1'b0},
    '{2'd2, 4'd4,  16'h3100, 8'd3,  1'b0},
    '{2'd1, 4'd15, 16'h2200, 8'd15, 1'b0},
    '{2'd0, 4'd0,  16'h1200, 8'd2,  1'b0},
    '{2'd0, 4'd2,  16'h4000, 8'd0,  1'b1},
    '{2'd1, 4'd6,  16'h5000, 8'd1,  1'b1},
    '{2'd2, 4'd10, 16'h6000, 8'd0,  1'b1},
    '{2'd0, 4'd12, 16'h4100, 8'd1,  1'b1},
    '{2'd1, 4'd7,  16'h5100, 8'd0,  1'b1},
    '{2'd2, 4'd11, 16'h6100, 8'd2,  1'b1}
  };

  logic clk;
  logic rst;

  logic [AXI_S_ID_W-1:0] aw_id;
  logic [ADDR_W-1:0]     aw_addr;
  logic                  aw_valid;
  logic                  aw_ready;
  logic [DATA_W-1:0]     w_data;
  logic [STRB_W-1:0]     w_strb;
  logic                  w_valid;
  logic                  w_ready;
  logic [AXI_S_ID_W-1:0] b_id;
  logic [AXI_RESP_W-1:0] b_resp;
  logic                  b_valid;
  logic                  b_ready;
  logic [AXI_S_ID_W-1:0] ar_id;
  logic [ADDR_W-1:0]     ar_addr;
  logic                  ar_valid;
  logic                  ar_ready;
  logic [AXI_S_ID_W-1:0] r_id;
  logic [DATA_W-1:0]     r_data;
  logic [AXI_RESP_W-1:0] r_resp;
  logic                  r_last;
  logic                  r_valid;
  logic                  r_ready;

  // Reader index 0 is fh, 1 is bh, 2 is raw
  logic [AXI_S_ID_W-1:0]  rd_ar_id    [3];
  logic [ADDR_W-1:0]      rd_ar_addr  [3];
  logic [AXI_LEN_W-1:0]   rd_ar_len   [3];
  logic [AXI_SIZE_W-1:0]  rd_ar_size  [3];
  logic [AXI_BURST_W-1:0] rd_ar_burst [3];
  logic [2:0]             rd_ar_valid;
  logic [2:0]             rd_ar_ready;
  logic [AXI_S_ID_W-1:0]  rd_r_id     [3];
  logic [DATA_W-1:0]      rd_r_data   [3];
  logic [AXI_RESP_W-1:0]  rd_r_resp   [3];
  logic [2:0]             rd_r_last;
  logic [2:0]             rd_r_valid;
  logic [2:0]             rd_r_ready;

  logic [AXI_M_ID_W-1:0]  mem_ar_id;
  logic [ADDR_W-1:0]      mem_ar_addr;
  logic [AXI_LEN_W-1:0]   mem_ar_len;
  logic [AXI_SIZE_W-1:0]  mem_ar_size;
  logic [AXI_BURST_W-1:0] mem_ar_burst;
  logic                   mem_ar_valid;
  logic                   mem_ar_ready;
  logic [AXI_M_ID_W-1:0]  mem_r_id;
  logic [DATA_W-1:0]      mem_r_data;
  logic [AXI_RESP_W-1:0]  mem_r_resp;
  logic                   mem_r_last;
  logic                   mem_r_valid;
  logic                   mem_r_ready;

  // Expected beats per reader as {last, data}
  logic [DATA_W:0] exp_q [3][$];
  logic [1:0]      arb_seen [$];
  logic            arb_on;
  int              csr_errors;
  int              read_errors;
  int              arb_errors;

  zstd_dec_wrapper #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .STRB_W(STRB_W)
  ) u_zstd_dec_wrapper (
    .fh_ar_id(rd_ar_id[0]),
    .fh_ar_addr(rd_ar_addr[0]),
    .fh_ar_len(rd_ar_len[0]),
    .fh_ar_size(rd_ar_size[0]),
    .fh_ar_burst(rd_ar_burst[0]),
    .fh_ar_valid(rd_ar_valid[0]),
    .fh_ar_ready(rd_ar_ready[0]),
    .fh_r_id(rd_r_id[0]),
    .fh_r_data(rd_r_data[0]),
    .fh_r_resp(rd_r_resp[0]),
    .fh_r_last(rd_r_last[0]),
    .fh_r_valid(rd_r_valid[0]),
    .fh_r_ready(rd_r_ready[0]),
    .bh_ar_id(rd_ar_id[1]),
    .bh_ar_addr(rd_ar_addr[1]),
    .bh_ar_len(rd_ar_len[1]),
    .bh_ar_size(rd_ar_size[1]),
    .bh_ar_burst(rd_ar_burst[1]),
    .bh_ar_valid(rd_ar_valid[1]),
    .bh_ar_ready(rd_ar_ready[1]),
    .bh_r_id(rd_r_id[1]),
    .bh_r_data(rd_r_data[1]),
    .bh_r_resp(rd_r_resp[1]),
    .bh_r_last(rd_r_last[1]),
    .bh_r_valid(rd_r_valid[1]),
    .bh_r_ready(rd_r_ready[1]),
    .raw_ar_id(rd_ar_id[2]),
    .raw_ar_addr(rd_ar_addr[2]),
    .raw_ar_len(rd_ar_len[2]),
    .raw_ar_size(rd_ar_size[2]),
    .raw_ar_burst(rd_ar_burst[2]),
    .raw_ar_valid(rd_ar_valid[2]),
    .raw_ar_ready(rd_ar_ready[2]),
    .raw_r_id(rd_r_id[2]),
    .raw_r_data(rd_r_data[2]),
    .raw_r_resp(rd_r_resp[2]),
    .raw_r_last(rd_r_last[2]),
    .raw_r_valid(rd_r_valid[2]),
    .raw_r_ready(rd_r_ready[2]),
    .*
  );

  tb_mem_model #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_mem_model (
    .clk(clk),
    .rst(rst),
    .ar_id(mem_ar_id),
    .ar_addr(mem_ar_addr),
    .ar_len(mem_ar_len),
    .ar_valid(mem_ar_valid),
    .ar_ready(mem_ar_ready),
    .r_id(mem_r_id),
    .r_data(mem_r_data),
    .r_resp(mem_r_resp),
    .r_last(mem_r_last),
    .r_valid(mem_r_valid),
    .r_ready(mem_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic csr_access(input int i);
    csr_op_t                op;
    logic [AXI_S_ID_W-1:0] id;
    op = CSR_TBL[i];
    id = AXI_S_ID_W'(i);
    if (op.wr) begin
      aw_id    = id;
      aw_addr  = op.addr;
      w_data   = op.data;
      w_strb   = op.strb;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      do @(posedge clk); while (!aw_ready);
      #2;
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      do @(posedge clk); while (!b_valid);
      assert (b_id == id && b_resp == op.exp_resp) else begin
        csr_errors++;
        $display("error %0t: csr row %0d write got bid %0h bresp %0d, expected %0h %0d",
                 $time, i, b_id, b_resp, id, op.exp_resp);
      end
    end else begin
      ar_id    = id;
      ar_addr  = op.addr;
      ar_valid = 1'b1;
      do @(posedge clk); while (!ar_ready);
      #2;
      ar_valid = 1'b0;
      do @(posedge clk); while (!r_valid);
      assert (r_id == id && r_data == op.exp_data && r_resp == op.exp_resp && r_last) else begin
        csr_errors++;
        $display("error %0t: csr row %0d read got rid %0h data %h resp %0d last %0b",
                 $time, i, r_id, r_data, r_resp, r_last);
      end
    end
    #2;
  endtask

  task automatic issue_read(input int i);
    rd_op_t op;
    int     p;
    op = RD_TBL[i];
    p  = int'(op.port);
    for (int k = 0; k <= int'(op.len); k++) begin
      exp_q[p].push_back({k == int'(op.len), 2'b00, op.port, op.src, 56'(op.addr) + 56'(k)});
    end
    rd_ar_id[p]    = op.src;
    rd_ar_addr[p]  = op.addr;
    rd_ar_len[p]   = op.len;
    rd_ar_valid[p] = 1'b1;
    do @(posedge clk); while (!rd_ar_ready[p]);
    #2;
    rd_ar_valid[p] = 1'b0;
  endtask

  task automatic issue_port_rows(input int p);
    for (int i = 0; i < RD_ROWS; i++) begin
      if (RD_TBL[i].conc && int'(RD_TBL[i].port) == p) begin
        issue_read(i);
      end
    end
  endtask

  task automatic wait_drained();
    do @(posedge clk); while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0);
    #2;
  endtask

  // Per-cycle checks on the CSR handshake, the memory port and the readers
  always @(posedge clk) begin
    logic [DATA_W:0] e;
    int              ap;
    if (!rst) begin
      assert (aw_ready == w_ready) else begin
        csr_errors++;
        $display("error %0t: aw_ready %0b and w_ready %0b differ", $time, aw_ready, w_ready);
      end
      assert ($countones(rd_r_valid) <= 1) else begin
        read_errors++;
        $display("error %0t: beat valid on more than one reader", $time);
      end
      for (int p = 0; p < 3; p++) begin
        if (rd_r_valid[p] && rd_r_ready[p]) begin
          assert (exp_q[p].size() != 0) else begin
            read_errors++;
            $display("error %0t: reader %0d got a beat it did not ask for", $time, p);
          end
          if (exp_q[p].size() != 0) begin
            e = exp_q[p].pop_front();
            assert (rd_r_data[p] == e[DATA_W-1:0] && rd_r_id[p] == e[59:56] &&
                    rd_r_last[p] == e[DATA_W] && rd_r_resp[p] == OK) else begin
              read_errors++;
              $display("error %0t: reader %0d got data %h id %0h last %0b, expected %h",
                       $time, p, rd_r_data[p], rd_r_id[p], rd_r_last[p], e);
            end
          end
        end
      end
      if (mem_ar_valid && mem_ar_ready) begin
        ap = int'(mem_ar_id[AXI_M_ID_W-1 -: AXI_PORT_W]);
        assert (ap < 3) else begin
          read_errors++;
          $display("error %0t: memory request tagged with port %0d", $time, ap);
        end
        if (ap < 3) begin
          assert (rd_ar_valid[ap] && mem_ar_id[AXI_S_ID_W-1:0] == rd_ar_id[ap] &&
                  mem_ar_addr == rd_ar_addr[ap] && mem_ar_len == rd_ar_len[ap] &&
                  mem_ar_size == rd_ar_size[ap] && mem_ar_burst == rd_ar_burst[ap]) else begin
            read_errors++;
            $display("error %0t: memory request %h size %0d burst %0d does not match port %0d",
                     $time, mem_ar_addr, mem_ar_size, mem_ar_burst, ap);
          end
        end
        if (arb_on) begin
          arb_seen.push_back(mem_ar_id[AXI_M_ID_W-1 -: AXI_PORT_W]);
        end
      end
    end
  end

  // Random back-pressure on the readers
  initial begin
    void'($urandom(23631));
    rd_r_ready = '0;
    forever begin
      @(posedge clk);
      #2;
      for (int p = 0; p < 3; p++) begin
        rd_r_ready[p] = ($urandom % 4) != 0;
      end
    end
  end

  initial begin
    repeat ((CSR_ROWS + RD_ROWS) * 200) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", (CSR_ROWS + RD_ROWS) * 200);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int         last_port;
    int         n_conc;
    logic [1:0] exp_port;
    rst         = 1'b1;
    aw_id       = '0;
    aw_addr     = '0;
    aw_valid    = 1'b0;
    w_data      = '0;
    w_strb      = '0;
    w_valid     = 1'b0;
    b_ready     = 1'b1;
    ar_id       = '0;
    ar_addr     = '0;
    ar_valid    = 1'b0;
    r_ready     = 1'b1;
    rd_ar_valid = '0;
    // Size and burst differ per reader
    for (int p = 0; p < 3; p++) begin
      rd_ar_id[p]    = '0;
      rd_ar_addr[p]  = '0;
      rd_ar_len[p]   = '0;
      rd_ar_size[p]  = 3'(3 - p);
      rd_ar_burst[p] = 2'((p + 1) % 3);
    end
    arb_on      = 1'b0;
    csr_errors  = 0;
    read_errors = 0;
    arb_errors  = 0;
    last_port   = 0;
    n_conc      = 0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int i = 0; i < CSR_ROWS; i++) begin
      csr_access(i);
    end

    for (int i = 0; i < RD_ROWS; i++) begin
      if (!RD_TBL[i].conc) begin
        issue_read(i);
        wait_drained();
        last_port = int'(RD_TBL[i].port);
      end else begin
        n_conc++;
      end
    end

    arb_on = 1'b1;
    fork
      issue_port_rows(0);
      issue_port_rows(1);
      issue_port_rows(2);
    join
    wait_drained();
    arb_on = 1'b0;

    // Grants rotate from the port after the last winner
    assert (arb_seen.size() == n_conc) else begin
      arb_errors++;
      $display("error %0t: %0d grants seen, expected %0d", $time, arb_seen.size(), n_conc);
    end
    for (int k = 0; k < arb_seen.size(); k++) begin
      exp_port = 2'((last_port + 1 + k) % 3);
      assert (arb_seen[k] == exp_port) else begin
        arb_errors++;
        $display("error %0t: grant %0d went to port %0d, expected %0d",
                 $time, k, arb_seen[k], exp_port);
      end
    end

    $display("errors: csr %0d, read %0d, arbitration %0d", csr_errors, read_errors, arb_errors);
    if (csr_errors + read_errors + arb_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
zstd_axi_pkg.sv
zstd_csr_pkg.sv
zstd_csr_regs.sv
zstd_mem_read_mux.sv
zstd_dec_wrapper.sv
tb_mem_model.sv
tb_zstd_dec_wrapper.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_zstd_dec_wrapper \
  -f tb.f -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a pass status"; exit 1; }
exit 0
